// File: tb.f
source/rv_core_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_lsu.sv
source/rv_tracer.sv
source/rv_core.sv
source/rv_core_wrapper.sv
verif/tb_rv_core.sv

// File: Makefile
# Verilator simulation of the RV32I subset core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_rv_core \
		-Mdir obj_dir -o Vtb_rv_core
	./obj_dir/Vtb_rv_core | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/tb_rv_core.sv
/*
  Testbench for the RV32I subset core wrapper
  Random program, req/gnt/rvalid memory models with random delays
  and an ISA model that checks every retirement record
*/
`default_nettype none

module tb_rv_core;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_0100;
  localparam logic [31:0] DATA_BASE = 32'h0000_2000;
  localparam int PROG_LEN     = 200;
  localparam int RESET_CYCLES = 16;
  localparam int IDLE_CYCLES  = 8;
  localparam int MAX_CYCLES   = PROG_LEN * 12 + RESET_CYCLES + IDLE_CYCLES;

  typedef enum int {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
    K_ADDI, K_ANDI, K_ORI, K_XORI,
    K_LUI, K_LW, K_SW, K_BEQ, K_BNE, K_JAL, K_ILL
  } kind_e;

  logic                clk_i;
  logic                rst_i;
  logic                fetch_enable_i;
  logic                core_sleep_o;
  logic                instr_req_o;
  logic                instr_gnt_i    = 1'b0;
  logic [31:0]         instr_addr_o;
  logic                instr_rvalid_i = 1'b0;
  logic [31:0]         instr_rdata_i  = '0;
  logic                data_req_o;
  logic                data_gnt_i     = 1'b0;
  logic                data_we_o;
  logic [31:0]         data_addr_o;
  logic [31:0]         data_wdata_o;
  logic                data_rvalid_i  = 1'b0;
  logic [31:0]         data_rdata_i   = '0;
  rv_core_pkg::trace_t trace_o;
  logic [31:0]         retired_cnt_o;

  // Program as generated, and its encoded words
  kind_e       prog_kind [PROG_LEN];
  logic [4:0]  prog_rd   [PROG_LEN];
  logic [4:0]  prog_rs1  [PROG_LEN];
  logic [4:0]  prog_rs2  [PROG_LEN];
  logic [31:0] prog_imm  [PROG_LEN];
  logic [31:0] imem      [PROG_LEN];

  logic [31:0] dmem       [256];
  logic [31:0] model_mem  [256];
  logic [31:0] model_regs [32];
  logic [31:0] model_pc;

  logic        fetch_busy;
  int          fetch_delay;
  int          fetch_idx;
  logic        first_fetch = 1'b1;
  logic        data_busy;
  int          data_delay;
  logic [7:0]  data_idx;
  logic [31:0] last_store_addr;
  logic [31:0] last_store_data;

  int   errors  = 0;
  int   records = 0;
  int   cycles  = 0;
  logic done    = 1'b0;

  rv_core_wrapper #(
    .BOOT_ADDR ( BOOT_ADDR )
  ) i_rv_core_wrapper (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .fetch_enable_i ( fetch_enable_i ),
    .core_sleep_o   ( core_sleep_o   ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .data_req_o     ( data_req_o     ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_we_o      ( data_we_o      ),
    .data_addr_o    ( data_addr_o    ),
    .data_wdata_o   ( data_wdata_o   ),
    .data_rvalid_i  ( data_rvalid_i  ),
    .data_rdata_i   ( data_rdata_i   ),
    .trace_o        ( trace_o        ),
    .retired_cnt_o  ( retired_cnt_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic int grant_wait();
    return $urandom_range(3, 0);
  endfunction

  function automatic int response_wait();
    return $urandom_range(3, 1);
  endfunction

  // Initial data contents depend on the full byte address
  function automatic logic [31:0] fill_word(logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] encode(kind_e kind, logic [4:0] rd, logic [4:0] rs1,
                                         logic [4:0] rs2, logic [31:0] imm);
    case (kind)
      K_ADD:  return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
      K_SUB:  return {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
      K_AND:  return {7'h00, rs2, rs1, 3'b111, rd, 7'h33};
      K_OR:   return {7'h00, rs2, rs1, 3'b110, rd, 7'h33};
      K_XOR:  return {7'h00, rs2, rs1, 3'b100, rd, 7'h33};
      K_SLT:  return {7'h00, rs2, rs1, 3'b010, rd, 7'h33};
      K_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'h13};
      K_ANDI: return {imm[11:0], rs1, 3'b111, rd, 7'h13};
      K_ORI:  return {imm[11:0], rs1, 3'b110, rd, 7'h13};
      K_XORI: return {imm[11:0], rs1, 3'b100, rd, 7'h13};
      K_LUI:  return {imm[31:12], rd, 7'h37};
      K_LW:   return {imm[11:0], rs1, 3'b010, rd, 7'h03};
      K_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
      K_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'h63};
      K_BNE:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'h63};
      K_JAL:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
      // Custom-0 opcode, outside the subset
      default: return {imm[24:0], 7'h0b};
    endcase
  endfunction

  task automatic build_program();
    int          sel;
    int          span;
    logic [31:0] rnd;
    kind_e       kind;
    for (int i = 0; i < PROG_LEN; i++) begin
      sel  = $urandom_range(99, 0);
      span = (PROG_LEN - 1 - i < 8) ? PROG_LEN - 1 - i : 8;
      rnd  = $urandom;
      prog_rd[i]  = 5'($urandom_range(30, 0));
      prog_rs1[i] = 5'($urandom_range(31, 0));
      prog_rs2[i] = 5'($urandom_range(31, 0));
      prog_imm[i] = {{20{rnd[11]}}, rnd[11:0]};
      if (i == 0) begin
        // x31 holds the data region base for every load and store
        kind        = K_LUI;
        prog_rd[i]  = 5'd31;
        prog_imm[i] = DATA_BASE;
      end else if (i == PROG_LEN - 1) begin
        // Jump to itself marks the end of the program
        kind        = K_JAL;
        prog_rd[i]  = 5'd0;
        prog_imm[i] = '0;
      end else if (sel < 6) begin
        kind        = K_ILL;
        prog_imm[i] = rnd;
      end else if (sel < 30) begin
        kind = kind_e'(int'(K_ADD) + $urandom_range(5, 0));
      end else if (sel < 48) begin
        kind = kind_e'(int'(K_ADDI) + $urandom_range(3, 0));
      end else if (sel < 54) begin
        kind        = K_LUI;
        prog_imm[i] = rnd & 32'hffff_f000;
      end else if (sel < 78) begin
        kind        = (sel < 66) ? K_LW : K_SW;
        prog_rs1[i] = 5'd31;
        prog_imm[i] = 32'($urandom_range(255, 0)) << 2;
      end else if (sel < 92) begin
        kind = sel[0] ? K_BNE : K_BEQ;
        if ($urandom_range(1, 0) == 1) begin
          prog_rs2[i] = prog_rs1[i];
        end
        prog_imm[i] = 32'($urandom_range(span, 1)) << 2;
      end else begin
        kind        = K_JAL;
        prog_imm[i] = 32'($urandom_range(span, 1)) << 2;
      end
      prog_kind[i] = kind;
      imem[i] = encode(kind, prog_rd[i], prog_rs1[i], prog_rs2[i], prog_imm[i]);
    end
  endtask

  // Steps the ISA model by one instruction and checks the record against it
  task automatic check_retirement();
    int          idx;
    logic [31:0] a, b, imm, res, nxt, addr;
    logic        we, ill, st;
    idx  = (model_pc - BOOT_ADDR) >> 2;
    a    = model_regs[prog_rs1[idx]];
    b    = model_regs[prog_rs2[idx]];
    imm  = prog_imm[idx];
    res  = '0;
    addr = a + imm;
    nxt  = model_pc + 32'd4;
    we   = 1'b1;
    ill  = 1'b0;
    st   = 1'b0;
    case (prog_kind[idx])
      K_ADD:  res = a + b;
      K_SUB:  res = a - b;
      K_AND:  res = a & b;
      K_OR:   res = a | b;
      K_XOR:  res = a ^ b;
      K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      K_ADDI: res = a + imm;
      K_ANDI: res = a & imm;
      K_ORI:  res = a | imm;
      K_XORI: res = a ^ imm;
      K_LUI:  res = imm;
      K_LW:   res = model_mem[addr[9:2]];
      K_SW: begin
        we = 1'b0;
        st = 1'b1;
        model_mem[addr[9:2]] = b;
        compare("store address", last_store_addr, addr);
        compare("store data", last_store_data, b);
      end
      K_BEQ: begin
        we = 1'b0;
        if (a == b) nxt = model_pc + imm;
      end
      K_BNE: begin
        we = 1'b0;
        if (a != b) nxt = model_pc + imm;
      end
      K_JAL: begin
        res = model_pc + 32'd4;
        nxt = model_pc + imm;
      end
      default: begin
        we  = 1'b0;
        ill = 1'b1;
      end
    endcase
    if (prog_rd[idx] == 5'd0) we = 1'b0;
    compare("pc", trace_o.pc, model_pc);
    compare("instr", trace_o.instr, imem[idx]);
    compare("rd_we", 32'(trace_o.rd_we), 32'(we));
    compare("rd_wdata", trace_o.rd_wdata, we ? res : 32'd0);
    compare("illegal", 32'(trace_o.illegal), 32'(ill));
    compare("mem_we", 32'(trace_o.mem_we), 32'(st));
    if (we) begin
      compare("rd", 32'(trace_o.rd), 32'(prog_rd[idx]));
      model_regs[prog_rd[idx]] = res;
    end
    records++;
    compare("retired_cnt_o", retired_cnt_o, 32'(records));
    if (idx == PROG_LEN - 1) done = 1'b1;
    model_pc = nxt;
  endtask

  // Instruction memory, read only
  always @(posedge clk_i) begin
    instr_gnt_i    <= 1'b0;
    instr_rvalid_i <= 1'b0;
    if (rst_i) begin
      fetch_busy  <= 1'b0;
      fetch_delay <= grant_wait();
    end else if (!fetch_busy) begin
      if (instr_req_o && (fetch_delay == 0)) begin
        if (first_fetch) begin
          compare("first fetch address", instr_addr_o, BOOT_ADDR);
          first_fetch <= 1'b0;
        end
        instr_gnt_i <= 1'b1;
        fetch_busy  <= 1'b1;
        fetch_idx   <= (instr_addr_o - BOOT_ADDR) >> 2;
        fetch_delay <= response_wait();
      end else if (instr_req_o) begin
        fetch_delay <= fetch_delay - 1;
      end
    end else if (fetch_delay == 1) begin
      instr_rvalid_i <= 1'b1;
      instr_rdata_i  <= (fetch_idx < PROG_LEN) ? imem[fetch_idx] : 32'h0;
      fetch_busy     <= 1'b0;
      fetch_delay    <= grant_wait();
    end else begin
      fetch_delay <= fetch_delay - 1;
    end
  end

  // Data memory, a write takes effect at its grant
  always @(posedge clk_i) begin
    data_gnt_i    <= 1'b0;
    data_rvalid_i <= 1'b0;
    if (rst_i) begin
      data_busy  <= 1'b0;
      data_delay <= grant_wait();
      for (int j = 0; j < 256; j++) begin
        dmem[j] <= fill_word(DATA_BASE + 32'(j) * 4);
      end
    end else if (!data_busy) begin
      if (data_req_o && (data_delay == 0)) begin
        if ((data_addr_o - DATA_BASE) >= 32'd1024) begin
          $display("Data access at %h lies outside the data region", data_addr_o);
          errors++;
        end
        data_gnt_i <= 1'b1;
        data_busy  <= 1'b1;
        data_idx   <= data_addr_o[9:2];
        data_delay <= response_wait();
        if (data_we_o) begin
          dmem[data_addr_o[9:2]] <= data_wdata_o;
          last_store_addr        <= data_addr_o;
          last_store_data        <= data_wdata_o;
        end
      end else if (data_req_o) begin
        data_delay <= data_delay - 1;
      end
    end else if (data_delay == 1) begin
      data_rvalid_i <= 1'b1;
      data_rdata_i  <= dmem[data_idx];
      data_busy     <= 1'b0;
      data_delay    <= grant_wait();
    end else begin
      data_delay <= data_delay - 1;
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the program did not complete within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hc73f484f));
    rst_i          <= 1'b1;
    fetch_enable_i <= 1'b0;
    build_program();
    for (int j = 0; j < 256; j++) begin
      model_mem[j] = fill_word(DATA_BASE + 32'(j) * 4);
    end
    for (int j = 0; j < 32; j++) begin
      model_regs[j] = '0;
    end
    model_pc = BOOT_ADDR;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;

    // Core must stay asleep until fetch is enabled
    repeat (IDLE_CYCLES) begin
      @(posedge clk_i);
      compare("instr_req_o while disabled", 32'(instr_req_o), 32'd0);
      compare("trace valid while disabled", 32'(trace_o.valid), 32'd0);
      compare("core_sleep_o while disabled", 32'(core_sleep_o), 32'd1);
    end
    fetch_enable_i <= 1'b1;

    while (!done) begin
      @(posedge clk_i);
      if (trace_o.valid) begin
        check_retirement();
      end
    end
    for (int j = 0; j < 256; j++) begin
      compare("data memory word", dmem[j], model_mem[j]);
    end

    $display("Retirements checked: %0d, errors: %0d", records, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/rv_core_wrapper.sv
/*
  Core wrapper
  Holds the RV32I subset core with its retirement tracer beside it
*/
`default_nettype none

module rv_core_wrapper #(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0000
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                fetch_enable_i,
  output logic                core_sleep_o,

  // Instruction memory
  output logic                instr_req_o,
  input  logic                instr_gnt_i,
  output logic [31:0]         instr_addr_o,
  input  logic                instr_rvalid_i,
  input  logic [31:0]         instr_rdata_i,

  // Data memory
  output logic                data_req_o,
  input  logic                data_gnt_i,
  output logic                data_we_o,
  output logic [31:0]         data_addr_o,
  output logic [31:0]         data_wdata_o,
  input  logic                data_rvalid_i,
  input  logic [31:0]         data_rdata_i,

  output rv_core_pkg::trace_t trace_o,
  output logic [31:0]         retired_cnt_o
);

  rv_core_pkg::trace_t core_trace;

  rv_core #(
    .BOOT_ADDR ( BOOT_ADDR )
  ) i_core (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .fetch_enable_i ( fetch_enable_i ),
    .core_sleep_o   ( core_sleep_o   ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .data_req_o     ( data_req_o     ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_we_o      ( data_we_o      ),
    .data_addr_o    ( data_addr_o    ),
    .data_wdata_o   ( data_wdata_o   ),
    .data_rvalid_i  ( data_rvalid_i  ),
    .data_rdata_i   ( data_rdata_i   ),
    .trace_o        ( core_trace     )
  );

  rv_tracer i_tracer (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .trace_i       ( core_trace    ),
    .trace_o       ( trace_o       ),
    .retired_cnt_o ( retired_cnt_o )
  );

endmodule

`default_nettype wire

// File: source/rv_core.sv
/*
  RV32I subset core
  Multi-cycle sequencer with fetch, execute and memory wait,
  program counter, ALU, branch resolution and write-back
*/
`default_nettype none

module rv_core #(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0000
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                fetch_enable_i,
  output logic                core_sleep_o,
  output logic                instr_req_o,
  input  logic                instr_gnt_i,
  output logic [31:0]         instr_addr_o,
  input  logic                instr_rvalid_i,
  input  logic [31:0]         instr_rdata_i,
  output logic                data_req_o,
  input  logic                data_gnt_i,
  output logic                data_we_o,
  output logic [31:0]         data_addr_o,
  output logic [31:0]         data_wdata_o,
  input  logic                data_rvalid_i,
  input  logic [31:0]         data_rdata_i,
  output rv_core_pkg::trace_t trace_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH_REQ,
    S_FETCH_WAIT,
    S_EXECUTE,
    S_MEM_WAIT
  } core_state_e;

  core_state_e           state_q;
  logic [31:0]           pc_q;
  rv_core_pkg::instr_u   instr_q;
  rv_core_pkg::ctrl_t    ctrl;
  rv_core_pkg::mem_req_t lsu_req;
  logic [31:0] imm;
  logic [31:0] rs1_data, rs2_data;
  logic [31:0] op_b, alu_result, wb_data;
  logic [31:0] pc_plus4, next_pc;
  logic [31:0] lsu_rdata;
  logic        lsu_done, is_mem, branch_taken, retire, rd_we;

  rv_decoder i_decoder (
    .instr_i ( instr_q ),
    .ctrl_o  ( ctrl    ),
    .imm_o   ( imm     )
  );

  rv_regfile i_regfile (
    .clk_i     ( clk_i      ),
    .rst_i     ( rst_i      ),
    .raddr_a_i ( ctrl.rs1   ),
    .raddr_b_i ( ctrl.rs2   ),
    .rdata_a_o ( rs1_data   ),
    .rdata_b_o ( rs2_data   ),
    .we_i      ( rd_we      ),
    .waddr_i   ( ctrl.rd    ),
    .wdata_i   ( wb_data    )
  );

  // ALU, SLT compares as signed
  assign op_b = ctrl.use_imm ? imm : rs2_data;

  always_comb begin
    case (ctrl.alu_op)
      rv_core_pkg::ALU_SUB: alu_result = rs1_data - op_b;
      rv_core_pkg::ALU_AND: alu_result = rs1_data & op_b;
      rv_core_pkg::ALU_OR:  alu_result = rs1_data | op_b;
      rv_core_pkg::ALU_XOR: alu_result = rs1_data ^ op_b;
      rv_core_pkg::ALU_SLT: alu_result = {31'd0, $signed(rs1_data) < $signed(op_b)};
      default:              alu_result = rs1_data + op_b;
    endcase
  end

  assign pc_plus4     = pc_q + 32'd4;
  assign branch_taken = ctrl.is_branch && ((rs1_data == rs2_data) ^ ctrl.branch_ne);
  assign next_pc      = (ctrl.is_jal || branch_taken) ? pc_q + imm : pc_plus4;

  assign wb_data = ctrl.is_lui  ? imm :
                   ctrl.is_jal  ? pc_plus4 :
                   ctrl.is_load ? lsu_rdata : alu_result;

  // Memory ops start in execute and retire when the LSU is done
  assign is_mem        = ctrl.is_load || ctrl.is_store;
  assign lsu_req.valid = (state_q == S_EXECUTE) && is_mem;
  assign lsu_req.we    = ctrl.is_store;
  assign lsu_req.addr  = alu_result;
  assign lsu_req.wdata = rs2_data;

  rv_lsu i_lsu (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .req_i         ( lsu_req       ),
    .done_o        ( lsu_done      ),
    .rdata_o       ( lsu_rdata     ),
    .data_req_o    ( data_req_o    ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_we_o     ( data_we_o     ),
    .data_addr_o   ( data_addr_o   ),
    .data_wdata_o  ( data_wdata_o  ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_rdata_i  ( data_rdata_i  )
  );

  assign retire = ((state_q == S_EXECUTE) && !is_mem) || ((state_q == S_MEM_WAIT) && lsu_done);
  // A write to x0 is not reported as a register write
  assign rd_we  = retire && ctrl.reg_write && (ctrl.rd != 5'd0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= S_IDLE;
      pc_q    <= BOOT_ADDR;
    end else begin
      case (state_q)
        S_IDLE:       if (fetch_enable_i) state_q <= S_FETCH_REQ;
        S_FETCH_REQ:  if (instr_gnt_i)    state_q <= S_FETCH_WAIT;
        S_FETCH_WAIT: if (instr_rvalid_i) state_q <= S_EXECUTE;
        S_EXECUTE:    if (is_mem)         state_q <= S_MEM_WAIT;
        default:      ;
      endcase
      if (retire) begin
        pc_q    <= next_pc;
        state_q <= fetch_enable_i ? S_FETCH_REQ : S_IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == S_FETCH_WAIT) && instr_rvalid_i) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o  = (state_q == S_FETCH_REQ);
  assign instr_addr_o = pc_q;
  assign core_sleep_o = (state_q == S_IDLE) && !fetch_enable_i;

  assign trace_o.valid    = retire;
  assign trace_o.pc       = pc_q;
  assign trace_o.instr    = instr_q;
  assign trace_o.rd       = ctrl.rd;
  assign trace_o.rd_we    = rd_we;
  assign trace_o.rd_wdata = rd_we ? wb_data : 32'd0;
  assign trace_o.illegal  = ctrl.illegal;
  assign trace_o.mem_we   = ctrl.is_store;

  a_fetch_held: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

`default_nettype wire

// File: source/rv_tracer.sv
/*
  Retirement tracer
  Registers each retirement record and counts retired instructions
*/
`default_nettype none

module rv_tracer (
  input  logic                clk_i,
  input  logic                rst_i,
  input  rv_core_pkg::trace_t trace_i,
  output rv_core_pkg::trace_t trace_o,
  output logic [31:0]         retired_cnt_o
);

  rv_core_pkg::trace_t rec_q;
  logic        valid_q;
  logic [31:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      valid_q <= trace_i.valid;
      // Wraps silently at 2^32
      if (trace_i.valid) begin
        cnt_q <= cnt_q + 32'd1;
      end
    end
  end

  // Record contents only change on a retirement
  always_ff @(posedge clk_i) begin
    if (trace_i.valid) begin
      rec_q <= trace_i;
    end
  end

  always_comb begin
    trace_o       = rec_q;
    trace_o.valid = valid_q;
  end

  assign retired_cnt_o = cnt_q;

endmodule

`default_nettype wire

// File: source/rv_lsu.sv
/*
  Load/store unit
  Runs one data-memory transaction at a time over the
  req/gnt/rvalid handshake and reports completion to the core
*/
`default_nettype none

module rv_lsu (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  rv_core_pkg::mem_req_t req_i,
  output logic                  done_o,
  output logic [31:0]           rdata_o,
  output logic                  data_req_o,
  input  logic                  data_gnt_i,
  output logic                  data_we_o,
  output logic [31:0]           data_addr_o,
  output logic [31:0]           data_wdata_o,
  input  logic                  data_rvalid_i,
  input  logic [31:0]           data_rdata_i
);

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_REQ,
    LSU_WAIT
  } lsu_state_e;

  lsu_state_e state_q;
  rv_core_pkg::mem_req_t req_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= LSU_IDLE;
    end else begin
      case (state_q)
        LSU_IDLE: if (req_i.valid)   state_q <= LSU_REQ;
        LSU_REQ:  if (data_gnt_i)    state_q <= LSU_WAIT;
        LSU_WAIT: if (data_rvalid_i) state_q <= LSU_IDLE;
        default:                     state_q <= LSU_IDLE;
      endcase
    end
  end

  // Request payload is captured once and held until the grant
  always_ff @(posedge clk_i) begin
    if ((state_q == LSU_IDLE) && req_i.valid) begin
      req_q <= req_i;
    end
  end

  assign data_req_o   = (state_q == LSU_REQ);
  assign data_we_o    = req_q.we;
  assign data_addr_o  = req_q.addr;
  assign data_wdata_o = req_q.wdata;

  // Writes get an rvalid too, its data is simply ignored
  assign done_o  = (state_q == LSU_WAIT) && data_rvalid_i;
  assign rdata_o = data_rdata_i;

  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o));

  a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == LSU_IDLE) |-> !data_rvalid_i);

endmodule

`default_nettype wire

// File: source/rv_regfile.sv
/*
  Integer register file
  Two combinational read ports and one write port, x0 hardwired to zero
*/
`default_nettype none

module rv_regfile (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [4:0]  raddr_a_i,
  input  logic [4:0]  raddr_b_i,
  output logic [31:0] rdata_a_o,
  output logic [31:0] rdata_b_o,
  input  logic        we_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i
);

  // Only x1..x31 have storage
  logic [31:0] regs_q [31:1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == 5'd0) ? 32'd0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == 5'd0) ? 32'd0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// File: source/rv_decoder.sv
/*
  Instruction decoder
  Turns one instruction word into control signals and a
  sign-extended immediate, purely combinational
*/
`default_nettype none

module rv_decoder (
  input  rv_core_pkg::instr_u instr_i,
  output rv_core_pkg::ctrl_t  ctrl_o,
  output logic [31:0]         imm_o
);

  always_comb begin
    ctrl_o        = '0;
    ctrl_o.alu_op = rv_core_pkg::ALU_ADD;
    ctrl_o.rd     = instr_i.r.rd;
    ctrl_o.rs1    = instr_i.r.rs1;
    ctrl_o.rs2    = instr_i.r.rs2;
    imm_o         = '0;

    case (instr_i.r.opcode)
      rv_core_pkg::OP: begin
        ctrl_o.reg_write = 1'b1;
        case ({instr_i.r.funct7, instr_i.r.funct3})
          {7'h00, 3'b000}: ctrl_o.alu_op = rv_core_pkg::ALU_ADD;
          {7'h20, 3'b000}: ctrl_o.alu_op = rv_core_pkg::ALU_SUB;
          {7'h00, 3'b111}: ctrl_o.alu_op = rv_core_pkg::ALU_AND;
          {7'h00, 3'b110}: ctrl_o.alu_op = rv_core_pkg::ALU_OR;
          {7'h00, 3'b100}: ctrl_o.alu_op = rv_core_pkg::ALU_XOR;
          {7'h00, 3'b010}: ctrl_o.alu_op = rv_core_pkg::ALU_SLT;
          default:         ctrl_o.illegal = 1'b1;
        endcase
      end
      rv_core_pkg::OP_IMM: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.use_imm   = 1'b1;
        imm_o            = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
        case (instr_i.i.funct3)
          3'b000:  ctrl_o.alu_op = rv_core_pkg::ALU_ADD;
          3'b111:  ctrl_o.alu_op = rv_core_pkg::ALU_AND;
          3'b110:  ctrl_o.alu_op = rv_core_pkg::ALU_OR;
          3'b100:  ctrl_o.alu_op = rv_core_pkg::ALU_XOR;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      rv_core_pkg::LUI: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.is_lui    = 1'b1;
        imm_o            = {instr_i.u.imm, 12'b0};
      end
      rv_core_pkg::LOAD: begin
        // Only full-word loads
        ctrl_o.reg_write = 1'b1;
        ctrl_o.is_load   = 1'b1;
        ctrl_o.use_imm   = 1'b1;
        ctrl_o.illegal   = (instr_i.i.funct3 != 3'b010);
        imm_o            = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
      end
      rv_core_pkg::STORE: begin
        ctrl_o.is_store = 1'b1;
        ctrl_o.use_imm  = 1'b1;
        ctrl_o.illegal  = (instr_i.s.funct3 != 3'b010);
        imm_o           = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
      end
      rv_core_pkg::BRANCH: begin
        // BEQ is funct3 000 and BNE is 001
        ctrl_o.is_branch = 1'b1;
        ctrl_o.branch_ne = instr_i.b.funct3[0];
        ctrl_o.illegal   = (instr_i.b.funct3[2:1] != 2'b00);
        imm_o            = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                            instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
      end
      rv_core_pkg::JAL: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.is_jal    = 1'b1;
        imm_o            = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                            instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // An illegal word must leave no architectural trace
    if (ctrl_o.illegal) begin
      ctrl_o.reg_write = 1'b0;
      ctrl_o.is_load   = 1'b0;
      ctrl_o.is_store  = 1'b0;
      ctrl_o.is_branch = 1'b0;
      ctrl_o.is_jal    = 1'b0;
      ctrl_o.is_lui    = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/rv_core_pkg.sv
/*
  RV32I subset core package
  Instruction word formats, major opcodes, ALU operation codes,
  decoded control and the retirement trace record
*/
`default_nettype none

package rv_core_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // Branch offset bits are scattered across the word
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // One instruction word, seen through each encoding format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  typedef struct packed {
    alu_op_e    alu_op;
    logic       use_imm;
    logic       reg_write;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       branch_ne;
    logic       is_jal;
    logic       is_lui;
    logic       illegal;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
  } ctrl_t;

  // Single data transaction from the core to the LSU
  typedef struct packed {
    logic        valid;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [4:0]  rd;
    logic        rd_we;
    logic [31:0] rd_wdata;
    logic        illegal;
    logic        mem_we;
  } trace_t;

endpackage

`default_nettype wire
